// File: Bender.yml
package:
  name: exec_unit

sources:
  # Design, in compile order
  - files:
      - rtl/aluPkg.sv
      - rtl/pipeIf.sv
      - rtl/instrDecode.sv
      - rtl/aluCore.sv
      - rtl/resultStage.sv
      - rtl/execUnit.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - dv/execUnit_chk.sv
      - dv/execUnitTb.sv

// File: dv/execGolden.txt
// instr rs1Data rs2Data pc, then expected illegal wbEn wbAddr wbData branchTaken branchTarget
// wbAddr and wbData count for ALU rows, branchTarget for branch rows only
002081B3 7FFFFFFF 00000001 00000100 0 1 03 80000000 0 00000000
402081B3 00000005 00000007 00000104 0 1 03 FFFFFFFE 0 00000000
0020F233 F0F0F0F0 FF00FF00 00000108 0 1 04 F000F000 0 00000000
0020E033 F0F0F0F0 FF00FF00 0000010C 0 0 00 FFF0FFF0 0 00000000
0020C1B3 F0F0F0F0 FF00FF00 00000110 0 1 03 0FF00FF0 0 00000000
0020A1B3 FFFFFFFF 00000001 00000114 0 1 03 00000001 0 00000000
0020B1B3 FFFFFFFF 00000001 00000118 0 1 03 00000000 0 00000000
002091B3 00000001 00000024 0000011C 0 1 03 00000010 0 00000000
0020D1B3 80000000 0000001F 00000120 0 1 03 00000001 0 00000000
4080D193 F0000000 0000FFFF 00000124 0 1 03 FFF00000 0 00000000
FFB08193 00000010 12345678 00000128 0 1 03 0000000B 0 00000000
022081B3 FFFFFFFF 00000003 0000012C 0 1 03 FFFFFFFD 0 00000000
022091B3 80000000 7FFFFFFF 00000130 0 1 03 C0000000 0 00000000
0220A1B3 FFFFFFFF FFFFFFFF 00000134 0 1 03 FFFFFFFF 0 00000000
0220B1B3 FFFFFFFF FFFFFFFF 00000138 0 1 03 FFFFFFFE 0 00000000
0220C1B3 00000007 00000000 0000013C 0 1 03 FFFFFFFF 0 00000000
0220C1B3 80000000 FFFFFFFF 00000140 0 1 03 80000000 0 00000000
0220D1B3 FFFFFFF9 00000002 00000144 0 1 03 7FFFFFFC 0 00000000
0220E1B3 80000000 FFFFFFFF 00000148 0 1 03 00000000 0 00000000
0220F1B3 12345678 00000000 0000014C 0 1 03 12345678 0 00000000
0A20C1B3 FFFFFFFF 00000001 00000150 0 1 03 FFFFFFFF 0 00000000
0A20E1B3 FFFFFFFF 00000001 00000154 0 1 03 00000001 0 00000000
0A20D1B3 FFFFFFFF 00000001 00000158 0 1 03 00000001 0 00000000
0A20F1B3 FFFFFFFF 00000001 0000015C 0 1 03 FFFFFFFF 0 00000000
00208863 0000ABCD 0000ABCD 00001000 0 0 00 00000000 1 00001010
FE209CE3 00000005 00000005 00002000 0 0 00 00000000 0 00001FF8
0020C0E3 FFFFFFFF 00000001 00003000 0 0 00 00000000 1 00003800
0020D863 80000000 7FFFFFFF 00004000 0 0 00 00000000 0 00004010
FE20ECE3 FFFFFFFF 00000001 00005000 0 0 00 00000000 0 00004FF8
0020F863 80000000 7FFFFFFF 00006000 0 0 00 00000000 1 00006010
002081FF 00000001 00000002 00000160 1 0 00 00000000 0 00000000
202081B3 00000001 00000002 00000164 1 0 00 00000000 0 00000000

// File: dv/execUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module execUnitTb;

  localparam int NumVec         = 32;
  localparam int Cols           = 10;
  localparam int MaxDrainCycles = 20;
  localparam int ColInstr       = 0;
  localparam int ColRs1         = 1;
  localparam int ColRs2         = 2;
  localparam int ColPc          = 3;
  localparam int ColIllegal     = 4;
  localparam int ColWbEn        = 5;
  localparam int ColWbAddr      = 6;
  localparam int ColWbData      = 7;
  localparam int ColTaken       = 8;
  localparam int ColTarget      = 9;

  logic        clk = 1'b0;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instr;
  logic [31:0] rs1Data;
  logic [31:0] rs2Data;
  logic [31:0] pc;
  logic        outValid;
  logic        illegal;
  logic        wbEn;
  logic [4:0]  wbAddr;
  logic [31:0] wbData;
  logic        branchTaken;
  logic [31:0] branchTarget;

  logic [31:0] golden [NumVec*Cols];
  int          vecQ[$];             // Vector index of each item in flight
  int          issueQ[$];           // Cycle in which each item was driven
  int          cycleCount     = 0;
  int          valueErrors    = 0;
  int          protocolErrors = 0;
  int          timeoutErrors  = 0;
  int          setupErrors    = 0;
  logic [31:0] rngState       = 32'd32563;

  execUnit #(.EnableMulDiv(1'b1)) uut (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instr        (instr),
    .rs1Data      (rs1Data),
    .rs2Data      (rs2Data),
    .pc           (pc),
    .outValid     (outValid),
    .illegal      (illegal),
    .wbEn         (wbEn),
    .wbAddr       (wbAddr),
    .wbData       (wbData),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  bind execUnit execUnit_chk protocolChk (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .outValid    (outValid),
    .illegal     (illegal),
    .wbEn        (wbEn),
    .branchTaken (branchTaken),
    .wbAddr      (wbAddr)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] nextRand(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic compareField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual, input int vec);
    assert (actual === expected) else begin
      $display("[ERROR] vector %0d %s expected %h got %h", vec, name, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic checkOutput(input int vec, input int issued);
    int   base;
    logic branchOp;
    base     = vec * Cols;
    branchOp = golden[base + ColInstr][6:0] == 7'h63; // RV32 BRANCH opcode
    assert (cycleCount - issued == 3) else begin
      $display("Vector %0d came out %0d cycles after its input instead of 3",
               vec, cycleCount - issued);
      protocolErrors++;
    end
    compareField("illegal", golden[base + ColIllegal], illegal, vec);
    compareField("wbEn", golden[base + ColWbEn], wbEn, vec);
    compareField("branchTaken", golden[base + ColTaken], branchTaken, vec);
    if (golden[base + ColIllegal] == 32'd0) begin
      if (branchOp) begin
        compareField("branchTarget", golden[base + ColTarget], branchTarget, vec);
      end else begin
        compareField("wbAddr", golden[base + ColWbAddr], wbAddr, vec);
        compareField("wbData", golden[base + ColWbData], wbData, vec);
      end
    end
  endtask

  // Outputs are sampled half a cycle after the edge that updates them
  always @(negedge clk) begin : monitor
    int vec;
    int issued;
    if (!rstN) begin
      assert (!outValid && !wbEn && !branchTaken && !illegal) else begin
        $display("Outputs are active while reset is asserted");
        protocolErrors++;
      end
    end
    if (outValid === 1'b1) begin
      if (vecQ.size() == 0) begin
        $display("outValid pulsed with no instruction in flight");
        protocolErrors++;
      end else begin
        vec    = vecQ.pop_front();
        issued = issueQ.pop_front();
        checkOutput(vec, issued);
      end
    end
    cycleCount++;
  end

  initial begin : driver
    int gap;
    int waited;
    int totalErrors;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    rs1Data    = '0;
    rs2Data    = '0;
    pc         = '0;
    $readmemh("dv/execGolden.txt", golden);
    if ($isunknown(golden[NumVec*Cols - 1])) begin
      $display("Golden file is missing or holds fewer than %0d vectors", NumVec);
      setupErrors++;
    end
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < NumVec; i++) begin
      @(posedge clk);
      instrValid <= 1'b1;
      instr      <= golden[i*Cols + ColInstr];
      rs1Data    <= golden[i*Cols + ColRs1];
      rs2Data    <= golden[i*Cols + ColRs2];
      pc         <= golden[i*Cols + ColPc];
      vecQ.push_back(i);
      issueQ.push_back(cycleCount);
      rngState = nextRand(rngState);
      gap      = (rngState >> 16) % 3; // Zero gap gives back-to-back items
      repeat (gap) begin
        @(posedge clk);
        instrValid <= 1'b0;
      end
    end
    @(posedge clk);
    instrValid <= 1'b0;
    waited = 0;
    while (vecQ.size() != 0 && waited < MaxDrainCycles) begin
      @(posedge clk);
      waited++;
    end
    if (vecQ.size() != 0) begin
      $display("Timed out waiting for %0d results that never came out", vecQ.size());
      timeoutErrors++;
    end
    repeat (4) @(posedge clk); // Let trailing assertions settle
    totalErrors = valueErrors + protocolErrors + timeoutErrors + setupErrors
                + uut.protocolChk.failCount;
    $display("Errors: %0d value, %0d protocol, %0d timeout, %0d setup, %0d assertion",
             valueErrors, protocolErrors, timeoutErrors, setupErrors,
             uut.protocolChk.failCount);
    if (totalErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/execUnit_chk.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit_chk (
  input logic       clk,
  input logic       rstN,
  input logic       instrValid,
  input logic       outValid,
  input logic       illegal,
  input logic       wbEn,
  input logic       branchTaken,
  input logic [4:0] wbAddr
);

  int failCount = 0; // Read by the testbench at the end

  // Three register stages from input to output
  assert property (@(posedge clk) disable iff (!rstN) instrValid |-> ##3 outValid)
    else begin
      $error("outValid missing three cycles after instrValid");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) outValid |-> $past(instrValid, 3))
    else begin
      $error("outValid without instrValid three cycles earlier");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) (wbEn || branchTaken) |-> outValid)
    else begin
      $error("wbEn or branchTaken high without outValid");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) wbEn |-> (wbAddr != 5'd0 && !illegal))
    else begin
      $error("wbEn asserted for x0 or for an illegal instruction");
      failCount++;
    end

endmodule

`default_nettype wire

// File: rtl/aluCore.sv
`timescale 1ns/10ps
`default_nettype none

module aluCore #(
  parameter bit EnableMulDiv = 1'b1
) (
  input  logic      clk,
  input  logic      rstN,
  decodeIf.consumer dec,
  executeIf.producer exe
);
  import aluPkg::*;

  logic [31:0] op1;
  logic [31:0] op2;
  logic [4:0]  shamt;
  logic        ltSigned;
  logic        ltUnsigned;
  logic [31:0] mulDivResult;
  logic [31:0] result;

  assign op1        = dec.operand1;
  assign op2        = dec.operand2;
  assign shamt      = op2[4:0];          // Low five bits only
  assign ltSigned   = $signed(op1) < $signed(op2);
  assign ltUnsigned = op1 < op2;

  if (EnableMulDiv) begin : gMulDiv
    logic signed [32:0] mulA;
    logic signed [32:0] mulB;
    logic signed [65:0] product;
    logic               divByZero;
    logic               overflow;
    logic signed [31:0] quotSigned;
    logic signed [31:0] remSigned;

    // One 33x33 signed multiplier covers all four variants
    assign mulA       = {(dec.aluOp == AluMulh || dec.aluOp == AluMulhsu) & op1[31], op1};
    assign mulB       = {(dec.aluOp == AluMulh) & op2[31], op2};
    assign product    = mulA * mulB;
    assign divByZero  = op2 == 32'd0;
    assign overflow   = op1 == 32'h8000_0000 && op2 == 32'hffff_ffff;
    assign quotSigned = $signed(op1) / $signed(op2);
    assign remSigned  = $signed(op1) % $signed(op2);

    always_comb begin
      case (dec.aluOp)
        AluMul:    mulDivResult = product[31:0];
        AluMulh,
        AluMulhsu,
        AluMulhu:  mulDivResult = product[63:32];
        AluDiv: begin
          if (divByZero)     mulDivResult = '1;
          else if (overflow) mulDivResult = op1;
          else               mulDivResult = quotSigned;
        end
        AluDivu:   mulDivResult = divByZero ? '1 : op1 / op2;
        AluRem: begin
          if (divByZero)     mulDivResult = op1;
          else if (overflow) mulDivResult = '0;
          else               mulDivResult = remSigned;
        end
        AluRemu:   mulDivResult = divByZero ? op1 : op1 % op2;
        default:   mulDivResult = '0;
      endcase
    end
  end else begin : gNoMulDiv
    assign mulDivResult = '0; // M ops decode as illegal here
  end

  always_comb begin
    case (dec.aluOp)
      AluAdd:  result = op1 + op2;
      AluSub:  result = op1 - op2;
      AluAnd:  result = op1 & op2;
      AluOr:   result = op1 | op2;
      AluXor:  result = op1 ^ op2;
      AluSll:  result = op1 << shamt;
      AluSrl:  result = op1 >> shamt;
      AluSra:  result = $signed(op1) >>> shamt;
      AluSlt:  result = {31'd0, ltSigned};
      AluSltu: result = {31'd0, ltUnsigned};
      AluBeq:  result = (op1 == op2) ? 32'd0 : 32'd1;
      AluBne:  result = (op1 != op2) ? 32'd0 : 32'd1;
      AluBlt:  result = ltSigned ? 32'd0 : 32'd1;
      AluBge:  result = ltSigned ? 32'd1 : 32'd0;
      AluBltu: result = ltUnsigned ? 32'd0 : 32'd1;
      AluBgeu: result = ltUnsigned ? 32'd1 : 32'd0;
      AluMin:  result = ltSigned ? op1 : op2;
      AluMax:  result = ltSigned ? op2 : op1;
      AluMinu: result = ltUnsigned ? op1 : op2;
      AluMaxu: result = ltUnsigned ? op2 : op1;
      AluMul, AluMulh, AluMulhsu, AluMulhu,
      AluDiv, AluDivu, AluRem, AluRemu: result = mulDivResult;
      default: result = op2;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exe.valid        <= 1'b0;
      exe.result       <= '0;
      exe.zero         <= 1'b0;
      exe.rdAddr       <= '0;
      exe.isBranch     <= 1'b0;
      exe.illegal      <= 1'b0;
      exe.branchTarget <= '0;
    end else begin
      exe.valid        <= dec.valid;
      exe.result       <= result;
      exe.zero         <= result == 32'd0; // Taken flag for branches
      exe.rdAddr       <= dec.rdAddr;
      exe.isBranch     <= dec.isBranch;
      exe.illegal      <= dec.illegal;
      exe.branchTarget <= dec.pc + dec.branchOffset;
    end
  end

endmodule

`default_nettype wire

// File: rtl/aluPkg.sv
`default_nettype none

package aluPkg;

  typedef enum logic [5:0] {
    AluAnd    = 6'b000000,
    AluOr     = 6'b000001,
    AluAdd    = 6'b000010,
    AluSll    = 6'b000011,
    AluSrl    = 6'b000100,
    AluXor    = 6'b000101,
    AluSub    = 6'b000110,
    AluSra    = 6'b000111,
    AluBeq    = 6'b001000, // Branch compares give 0 when taken
    AluBne    = 6'b001001,
    AluBlt    = 6'b001010,
    AluBge    = 6'b001011,
    AluBltu   = 6'b001100,
    AluBgeu   = 6'b001101,
    AluMul    = 6'b010000,
    AluMulh   = 6'b010001,
    AluMulhsu = 6'b010010,
    AluMulhu  = 6'b010011,
    AluDiv    = 6'b010100,
    AluDivu   = 6'b010101,
    AluRem    = 6'b010110,
    AluRemu   = 6'b010111,
    AluSlt    = 6'b011000,
    AluSltu   = 6'b011001,
    AluMin    = 6'b100000,
    AluMax    = 6'b100001,
    AluMinu   = 6'b100010,
    AluMaxu   = 6'b100011,
    AluPass2  = 6'b111111  // Passes operand 2
  } aluOpE;

  localparam logic [6:0] OpcodeOp     = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
  localparam logic [6:0] OpcodeBranch = 7'b1100011;

  localparam logic [6:0] Funct7Base   = 7'b0000000;
  localparam logic [6:0] Funct7Alt    = 7'b0100000; // SUB and SRA
  localparam logic [6:0] Funct7MulDiv = 7'b0000001;
  localparam logic [6:0] Funct7MinMax = 7'b0000101;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rType;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } iType;
    struct packed {
      logic       imm12;    // Sign bit of the offset
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
    } bType;
  } instrU;

endpackage

`default_nettype wire

// File: rtl/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit #(
  parameter bit EnableMulDiv = 1'b1
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        instrValid,
  input  logic [31:0] instr,
  input  logic [31:0] rs1Data,
  input  logic [31:0] rs2Data,
  input  logic [31:0] pc,
  output logic        outValid,
  output logic        illegal,
  output logic        wbEn,
  output logic [4:0]  wbAddr,
  output logic [31:0] wbData,
  output logic        branchTaken,
  output logic [31:0] branchTarget
);

  decodeIf  decIf ();
  executeIf exeIf ();

  instrDecode #(.EnableMulDiv(EnableMulDiv)) uDecode (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .pc         (pc),
    .dec        (decIf.producer)
  );

  aluCore #(.EnableMulDiv(EnableMulDiv)) uAlu (
    .clk  (clk),
    .rstN (rstN),
    .dec  (decIf.consumer),
    .exe  (exeIf.producer)
  );

  resultStage uResult (
    .clk          (clk),
    .rstN         (rstN),
    .exe          (exeIf.consumer),
    .outValid     (outValid),
    .illegal      (illegal),
    .wbEn         (wbEn),
    .branchTaken  (branchTaken),
    .wbAddr       (wbAddr),
    .wbData       (wbData),
    .branchTarget (branchTarget)
  );

endmodule

`default_nettype wire

// File: rtl/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode #(
  parameter bit EnableMulDiv = 1'b1
) (
  input  logic         clk,
  input  logic         rstN,
  input  logic         instrValid,
  input  aluPkg::instrU instr,
  input  logic [31:0]  rs1Data,
  input  logic [31:0]  rs2Data,
  input  logic [31:0]  pc,
  decodeIf.producer    dec
);
  import aluPkg::*;

  aluOpE       aluOpNext;
  logic [31:0] operand2Next;
  logic [4:0]  rdNext;
  logic        isBranchNext;
  logic        illegalNext;
  logic [31:0] offsetNext;

  always_comb begin
    aluOpNext    = AluPass2;
    operand2Next = rs2Data;
    rdNext       = instr.rType.rd;
    isBranchNext = 1'b0;
    illegalNext  = 1'b0;
    offsetNext   = {{20{instr.bType.imm12}}, instr.bType.imm11, instr.bType.imm10to5,
                    instr.bType.imm4to1, 1'b0};
    case (instr.rType.opcode)
      OpcodeOp: begin
        case (instr.rType.funct7)
          Funct7Base: begin
            case (instr.rType.funct3)
              3'b000:  aluOpNext = AluAdd;
              3'b001:  aluOpNext = AluSll;
              3'b010:  aluOpNext = AluSlt;
              3'b011:  aluOpNext = AluSltu;
              3'b100:  aluOpNext = AluXor;
              3'b101:  aluOpNext = AluSrl;
              3'b110:  aluOpNext = AluOr;
              default: aluOpNext = AluAnd;
            endcase
          end
          Funct7Alt: begin
            case (instr.rType.funct3)
              3'b000:  aluOpNext = AluSub;
              3'b101:  aluOpNext = AluSra;
              default: illegalNext = 1'b1;
            endcase
          end
          Funct7MulDiv: begin
            aluOpNext   = aluOpE'({3'b010, instr.rType.funct3}); // MUL..REMU in funct3 order
            illegalNext = !EnableMulDiv;
          end
          Funct7MinMax: begin
            case (instr.rType.funct3)
              3'b100:  aluOpNext = AluMin;
              3'b101:  aluOpNext = AluMinu;
              3'b110:  aluOpNext = AluMax;
              3'b111:  aluOpNext = AluMaxu;
              default: illegalNext = 1'b1;
            endcase
          end
          default: illegalNext = 1'b1;
        endcase
      end
      OpcodeOpImm: begin
        operand2Next = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
        case (instr.iType.funct3)
          3'b000: aluOpNext = AluAdd;
          3'b010: aluOpNext = AluSlt;
          3'b011: aluOpNext = AluSltu;
          3'b100: aluOpNext = AluXor;
          3'b110: aluOpNext = AluOr;
          3'b111: aluOpNext = AluAnd;
          3'b001: begin
            aluOpNext   = AluSll;
            illegalNext = instr.rType.funct7 != Funct7Base;
          end
          default: begin // SRLI or SRAI, told apart by funct7
            aluOpNext   = (instr.rType.funct7 == Funct7Alt) ? AluSra : AluSrl;
            illegalNext = instr.rType.funct7 != Funct7Base && instr.rType.funct7 != Funct7Alt;
          end
        endcase
      end
      OpcodeBranch: begin
        isBranchNext = 1'b1;
        rdNext       = 5'd0;
        case (instr.bType.funct3)
          3'b000:  aluOpNext = AluBeq;
          3'b001:  aluOpNext = AluBne;
          3'b100:  aluOpNext = AluBlt;
          3'b101:  aluOpNext = AluBge;
          3'b110:  aluOpNext = AluBltu;
          3'b111:  aluOpNext = AluBgeu;
          default: illegalNext = 1'b1;
        endcase
      end
      default: illegalNext = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dec.valid        <= 1'b0;
      dec.aluOp        <= aluOpE'(6'd0);
      dec.operand1     <= '0;
      dec.operand2     <= '0;
      dec.rdAddr       <= '0;
      dec.isBranch     <= 1'b0;
      dec.illegal      <= 1'b0;
      dec.pc           <= '0;
      dec.branchOffset <= '0;
    end else begin
      dec.valid        <= instrValid;
      dec.aluOp        <= aluOpNext;
      dec.operand1     <= rs1Data;
      dec.operand2     <= operand2Next;
      dec.rdAddr       <= rdNext;
      dec.isBranch     <= isBranchNext;
      dec.illegal      <= illegalNext;
      dec.pc           <= pc;
      dec.branchOffset <= offsetNext;
    end
  end

endmodule

`default_nettype wire

// File: rtl/pipeIf.sv
`timescale 1ns/10ps
`default_nettype none

interface decodeIf;
  import aluPkg::*;

  logic        valid;
  aluOpE       aluOp;
  logic [31:0] operand1;
  logic [31:0] operand2;
  logic [4:0]  rdAddr;
  logic        isBranch;
  logic        illegal;
  logic [31:0] pc;
  logic [31:0] branchOffset; // Sign-extended B immediate

  modport producer(output valid, aluOp, operand1, operand2, rdAddr, isBranch, illegal,
                   pc, branchOffset);
  modport consumer(input valid, aluOp, operand1, operand2, rdAddr, isBranch, illegal,
                   pc, branchOffset);
endinterface

interface executeIf;
  logic        valid;
  logic [31:0] result;
  logic        zero;
  logic [4:0]  rdAddr;
  logic        isBranch;
  logic        illegal;
  logic [31:0] branchTarget;

  modport producer(output valid, result, zero, rdAddr, isBranch, illegal, branchTarget);
  modport consumer(input valid, result, zero, rdAddr, isBranch, illegal, branchTarget);
endinterface

`default_nettype wire

// File: rtl/resultStage.sv
`timescale 1ns/10ps
`default_nettype none

module resultStage (
  input  logic       clk,
  input  logic       rstN,
  executeIf.consumer exe,
  output logic       outValid,
  output logic       illegal,
  output logic       wbEn,
  output logic       branchTaken,
  output logic [4:0] wbAddr,
  output logic [31:0] wbData,
  output logic [31:0] branchTarget
);

  logic legal;

  assign legal = exe.valid && !exe.illegal;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid     <= 1'b0;
      illegal      <= 1'b0;
      wbEn         <= 1'b0;
      branchTaken  <= 1'b0;
      wbAddr       <= '0;
      wbData       <= '0;
      branchTarget <= '0;
    end else begin
      outValid    <= exe.valid;
      illegal     <= exe.valid && exe.illegal;
      wbEn        <= legal && !exe.isBranch && exe.rdAddr != 5'd0; // x0 writes dropped
      branchTaken <= legal && exe.isBranch && exe.zero;
      if (exe.valid) begin // Hold payload between items
        wbAddr       <= exe.rdAddr;
        wbData       <= exe.result;
        branchTarget <= exe.branchTarget;
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
rtl/aluPkg.sv
rtl/pipeIf.sv
rtl/instrDecode.sv
rtl/aluCore.sv
rtl/resultStage.sv
rtl/execUnit.sv
dv/execUnit_chk.sv
dv/execUnitTb.sv
